//--- all.f
+incdir+common
+incdir+bench
common/card_pkg.sv
logic/vga_timing.sv
card/card_renderer.sv
card/sprite_store.sv
logic/board_regs.sv
logic/card_display_top.sv
bench/tb_card_display.sv

//--- bench/tb_card_tasks.svh
`ifndef TB_CARD_TASKS_SVH
`define TB_CARD_TASKS_SVH

////////////////////////////////////////////////////////////
// Wishbone master
////////////////////////////////////////////////////////////

// Ack is seen one ns after the edge that raised it
task automatic await_ack(input logic [`WB_ADR_W-1:0] adr);
	int waited;
	waited = 0;
	do begin
		@(posedge clk);
		#1;
		waited++;
		if (waited > BUS_STALL_LIMIT) begin
			$display("Bus cycle at address %h was never acknowledged", adr);
			abort_run();
		end
	end while (!wb_ack);
endtask

// Request held through the edge where ack is high
task automatic release_bus();
	@(posedge clk);
	#1;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
endtask

task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] data);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = 1'b1;
	wb_adr = adr;
	wb_dat_w = data;
	wb_sel = 4'hf;
	await_ack(adr);
	release_bus();
endtask

task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] data);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = 1'b0;
	wb_adr = adr;
	wb_sel = 4'hf;
	await_ack(adr);
	data = wb_dat_r;
	release_bus();
endtask

////////////////////////////////////////////////////////////
// Beam tracking on the output syncs
////////////////////////////////////////////////////////////

task automatic tick();
	hs_last = hs_now;
	vs_last = vs_now;
	@(posedge clk);
	#1;
	hs_now = hsync;
	vs_now = vsync;
	since_fall++;
endtask

task automatic wait_hsync_fall();
	do begin
		tick();
	end while (!(hs_last && !hs_now));
	since_fall = 0;
endtask

// First tick only refreshes the stored sync levels
task automatic wait_vsync_fall();
	tick();
	do begin
		tick();
	end while (!(vs_last && !vs_now));
	// Lines 490..524 still come before line 0
	line_next = `V_SYNC_START - `V_TOTAL;
	since_fall = 0;
endtask

task automatic wait_line(input int y);
	while (line_next < y) begin
		wait_hsync_fall();
		line_next++;
	end
endtask

// Pixel x lands 800 - 656 + x cycles after the hsync fall
task automatic sample_pixel(input int x, output pixel_t p);
	int target;
	target = `H_TOTAL - `H_SYNC_START + x;
	if (since_fall > target) begin
		$display("Sample point x=%0d was requested after the beam had passed it", x);
		abort_run();
	end
	while (since_fall < target) begin
		tick();
	end
	p = rgb;
endtask

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
	if (act !== exp) begin
		$display("FAIL %s expected %0d actual %0d", name, exp, act);
		abort_run();
	end
endtask

task automatic check_entry(input string name, input card_entry_t exp, input card_entry_t act);
	if (act !== exp) begin
		$display("FAIL %s expected face %0d state %0d actual face %0d state %0d",
			name, exp.face, exp.state, act.face, act.state);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("FAIL %s expected %b actual %b", name, exp, act);
		abort_run();
	end
endtask

`endif

//--- bench/tb_card_display.sv
`include "card_cfg.svh"

module tb_card_display import card_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Six frames cover the screen scans with margin
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 20000;
	localparam int BUS_STALL_LIMIT = 2000;
	localparam int CORNER = 10;

	// Card 6 sits in row 1, column 2
	localparam int CARD6_X = `GRID_X0 + 2 * `GRID_PITCH;
	localparam int CARD6_Y = `GRID_Y0 + 1 * `GRID_PITCH;

	localparam int SHOW_FACE = 0;
	localparam int SHOW_BACK = 1;
	localparam int SHOW_NONE = 2;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`WB_ADR_W-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0] wb_sel;
	logic wb_ack;
	logic [31:0] wb_dat_r;
	pixel_t rgb;
	logic hsync;
	logic vsync;

	int seed;
	int cycle_count = 0;
	card_entry_t entry_model [16];
	pixel_t face_model [CORNER][CORNER];
	pixel_t back_model [CORNER][CORNER];

	// Beam position as seen on the output syncs
	logic hs_now;
	logic hs_last;
	logic vs_now;
	logic vs_last;
	int line_next;
	int since_fall;

	card_display_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "tb_card_tasks.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests still running after %0d cycles", cycle_count);
			abort_run();
		end
	end

	function automatic logic [`WB_ADR_W-1:0] sprite_addr(input int face, input int lx,
		input int ly);
		return `WB_ADR_W'(`SPRITE_BASE + face * `SPRITE_PIXELS + ly * `CARD_W + lx);
	endfunction

	// Register word layout, face in bits 3:0 and state in bits 5:4
	function automatic logic [31:0] entry_to_word(input card_entry_t e);
		return {26'd0, 2'(e.state), e.face};
	endfunction

	function automatic card_entry_t word_to_entry(input logic [31:0] data);
		card_entry_t e;
		e.face = data[3:0];
		e.state = card_state_e'(data[5:4]);
		return e;
	endfunction

	function automatic pixel_t expected_at(input int which, input int lx, input int ly);
		if (which == SHOW_FACE) begin
			return face_model[ly][lx];
		end else if (which == SHOW_BACK) begin
			return back_model[ly][lx];
		end
		return '0;
	endfunction

	////////////////////////////////////////////////////////////
	// Screen scan, all points in raster order within one frame
	////////////////////////////////////////////////////////////

	task automatic scan_board(input string name, input int which);
		pixel_t got;
		wait_vsync_fall();
		wait_line(50);
		sample_pixel(100, got);
		check_pixel({name, " background (100,50)"}, '0, got);
		for (int ly = 0; ly < CORNER; ly++) begin
			wait_line(CARD6_Y + ly);
			if (ly == 0) begin
				// Gap between columns 0 and 1
				sample_pixel(215, got);
				check_pixel({name, " gap (215,170)"}, '0, got);
			end
			for (int lx = 0; lx < CORNER; lx++) begin
				sample_pixel(CARD6_X + lx, got);
				check_pixel($sformatf("%s card 6 at (%0d,%0d)", name, lx, ly),
					expected_at(which, lx, ly), got);
			end
		end
		wait_line(450);
		sample_pixel(600, got);
		check_pixel({name, " background (600,450)"}, '0, got);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_behaviour();
		logic [31:0] data;
		card_entry_t exp;
		repeat (5) begin
			@(posedge clk);
			#1;
			check_bit("reset hsync", 1'b1, hsync);
			check_bit("reset vsync", 1'b1, vsync);
			check_pixel("reset rgb", '0, rgb);
			check_bit("reset wb_ack", 1'b0, wb_ack);
		end
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_bit("after reset hsync", 1'b1, hsync);
		check_bit("after reset vsync", 1'b1, vsync);
		check_pixel("after reset rgb", '0, rgb);
		check_bit("after reset wb_ack", 1'b0, wb_ack);
		wb_read(`WB_ADR_W'(5), data);
		exp.state = hidden;
		exp.face = '0;
		check_entry("reset entry 5", exp, word_to_entry(data));
	endtask

	task automatic register_readback();
		logic [31:0] data;
		for (int i = 0; i < 16; i++) begin
			entry_model[i].face = face_t'($random(seed));
			entry_model[i].state = card_state_e'(2'(unsigned'($random(seed)) % 3));
			wb_write(`WB_ADR_W'(i), entry_to_word(entry_model[i]));
		end
		for (int i = 0; i < 16; i++) begin
			wb_read(`WB_ADR_W'(i), data);
			check_entry($sformatf("register readback entry %0d", i), entry_model[i],
				word_to_entry(data));
		end
	endtask

	task automatic reveal_face();
		card_entry_t entry;
		// Card 6 is on screen while its sprite is written
		entry.state = revealed;
		entry.face = 4'd3;
		wb_write(`WB_ADR_W'(6), entry_to_word(entry));
		// Sprite writes overlap the card rows, so some of them stall behind reads
		wait_vsync_fall();
		wait_line(CARD6_Y);
		for (int ly = 0; ly < CORNER; ly++) begin
			for (int lx = 0; lx < CORNER; lx++) begin
				face_model[ly][lx] = pixel_t'($random(seed));
				back_model[ly][lx] = pixel_t'($random(seed));
				wb_write(sprite_addr(3, lx, ly), 32'(face_model[ly][lx]));
				wb_write(sprite_addr(`BACK_FACE, lx, ly), 32'(back_model[ly][lx]));
			end
		end
		scan_board("reveal face", SHOW_FACE);
	endtask

	task automatic hide_card();
		card_entry_t entry;
		entry.state = hidden;
		entry.face = 4'd3;
		wb_write(`WB_ADR_W'(6), entry_to_word(entry));
		scan_board("hide card", SHOW_BACK);
	endtask

	task automatic match_card();
		card_entry_t entry;
		entry.state = matched;
		entry.face = 4'd3;
		wb_write(`WB_ADR_W'(6), entry_to_word(entry));
		scan_board("match card", SHOW_NONE);
	endtask

	initial begin
		seed = 32'hffd2a642;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		hs_now = 1'b1;
		hs_last = 1'b1;
		vs_now = 1'b1;
		vs_last = 1'b1;
		line_next = 0;
		since_fall = 0;
		reset_behaviour();
		register_readback();
		reveal_face();
		hide_card();
		match_card();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- card/card_renderer.sv
`include "card_cfg.svh"

module card_renderer import card_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [9:0] hcount,
	input logic [9:0] vcount,
	input logic hsync_raw,
	input logic vsync_raw,
	input logic active,
	input card_entry_t [15:0] card_table,
	output logic rd_en,
	output logic [15:0] rd_addr,
	input pixel_t rd_pixel,
	output pixel_t rgb,
	output logic hsync,
	output logic vsync
);

	logic col_hit;
	logic row_hit;
	logic [1:0] col_idx;
	logic [1:0] row_idx;
	logic [6:0] lx;
	logic [6:0] ly;
	card_entry_t entry;
	face_t sprite_idx;
	logic show_q;
	logic hsync_q;
	logic vsync_q;

	// Which of the four card windows along one axis holds pos, and where in it
	function automatic void locate(
		input logic [9:0] pos,
		input int origin,
		output logic hit,
		output logic [1:0] idx,
		output logic [6:0] offs
	);
		int start;
		hit = 1'b0;
		idx = '0;
		offs = '0;
		for (int i = 0; i < `GRID_DIM; i++) begin
			start = origin + i * `GRID_PITCH;
			if (int'(pos) >= start && int'(pos) < start + `CARD_W) begin
				hit = 1'b1;
				idx = 2'(i);
				offs = 7'(int'(pos) - start);
			end
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1, card lookup and sprite read
	////////////////////////////////////////////////////////////

	always_comb begin
		locate(hcount, `GRID_X0, col_hit, col_idx, lx);
		locate(vcount, `GRID_Y0, row_hit, row_idx, ly);
		entry = card_table[{row_idx, col_idx}];
		// Revealed cards only ever carry faces 0..7
		if (entry.state == hidden) begin
			sprite_idx = face_t'(`BACK_FACE);
		end else begin
			sprite_idx = {1'b0, entry.face[2:0]};
		end
		rd_en = col_hit && row_hit && (entry.state != matched);
		rd_addr = 16'(sprite_idx * `SPRITE_PIXELS + ly * `CARD_W + lx);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			show_q <= 1'b0;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			show_q <= rd_en && active;
			hsync_q <= hsync_raw;
			vsync_q <= vsync_raw;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2, pixel out with matching sync delay
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			rgb <= show_q ? rd_pixel : pixel_t'(0);
			hsync <= hsync_q;
			vsync <= vsync_q;
		end
	end

	// Board geometry has to stay inside the visible area
	a_rd_in_active: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> active);

endmodule

//--- card/sprite_store.sv
`include "card_cfg.svh"

module sprite_store import card_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rd_en,
	input logic [15:0] rd_addr,
	output pixel_t rd_pixel,
	input logic spr_req,
	input logic [15:0] spr_addr,
	input pixel_t spr_pixel,
	output logic spr_done
);

	localparam int DEPTH = (`FACE_COUNT + 1) * `SPRITE_PIXELS;

	pixel_t mem [DEPTH];
	store_state_e state;
	logic wr_en;
	logic addr_ok;

	////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////

	// Renderer owns the port whenever it reads
	assign wr_en = (state == host_write) && spr_req && !rd_en;

	// Writes past the last sprite are dropped but still acknowledged
	assign addr_ok = int'(spr_addr) < DEPTH;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			spr_done <= 1'b0;
		end else begin
			spr_done <= 1'b0;
			case (state)
				idle: begin
					if (spr_req) begin
						state <= host_write;
					end
				end
				host_write: begin
					if (wr_en) begin
						state <= host_ack;
						spr_done <= 1'b1;
					end else if (!spr_req) begin
						state <= idle;
					end
				end
				host_ack: begin
					// Hold until the bus side lets go of the request
					if (!spr_req) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Memory, single port shared by both sides
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en && addr_ok) begin
			mem[spr_addr] <= spr_pixel;
		end
		if (rd_en) begin
			rd_pixel <= mem[rd_addr];
		end
	end

	// Done pulse follows a write slot free of renderer reads
	a_write_gap: assert property (@(posedge clk) disable iff (!rst_n)
		spr_done |-> $past((state == host_write) && !rd_en));

	// Bus side must still be waiting when done arrives
	a_done_req: assert property (@(posedge clk) disable iff (!rst_n)
		spr_done |-> spr_req);

endmodule

//--- common/card_cfg.svh
`ifndef CARD_CFG_SVH
`define CARD_CFG_SVH

// 640x480 at 60 Hz, one pixel per clock
`define H_ACTIVE 640
`define H_TOTAL 800
`define H_SYNC_START 656
`define H_SYNC_END 752
`define V_ACTIVE 480
`define V_TOTAL 525
`define V_SYNC_START 490
`define V_SYNC_END 492

// 4x4 board of square cards
`define CARD_W 83
`define CARD_H 83
`define GRID_X0 130
`define GRID_Y0 70
`define GRID_PITCH 100
`define GRID_DIM 4

// Eight faces plus the card back, stored face after face
`define FACE_COUNT 8
`define BACK_FACE 8
`define SPRITE_PIXELS 6889

`define WB_ADR_W 17
`define SPRITE_BASE 17'h10000
`define PIPE_DELAY 2
`endif

//--- common/card_pkg.sv
package card_pkg;

	// 3-bit rgb, one bit per colour
	typedef logic [2:0] pixel_t;

	// Sprite index, faces 0..7 and the back at 8
	typedef logic [3:0] face_t;

	typedef enum logic [1:0] {
		hidden = 2'd0,
		revealed = 2'd1,
		matched = 2'd2
	} card_state_e;

	// One board entry, state in bits 5:4 and face in 3:0
	typedef struct packed {
		card_state_e state;
		face_t face;
	} card_entry_t;

	// Host write arbitration on the sprite memory
	typedef enum logic [1:0] {
		idle = 2'd0,
		host_write = 2'd1,
		host_ack = 2'd2
	} store_state_e;

endpackage

//--- logic/board_regs.sv
`include "card_cfg.svh"

module board_regs import card_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`WB_ADR_W-1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic [3:0] wb_sel,
	output logic wb_ack,
	output logic [31:0] wb_dat_r,
	output card_entry_t [15:0] card_table,
	output logic spr_req,
	output logic [15:0] spr_addr,
	output pixel_t spr_pixel,
	input logic spr_done
);

	logic bus_req;
	logic spr_wr;
	logic in_table;
	logic reg_go;
	logic reg_ack;
	logic ack_q;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	assign bus_req = wb_cyc && wb_stb;
	assign spr_wr = wb_we && (wb_adr >= `SPRITE_BASE);
	assign in_table = wb_adr < `WB_ADR_W'(`GRID_DIM * `GRID_DIM);

	// Everything but a sprite write is answered here in one cycle
	assign reg_go = bus_req && !spr_wr && !wb_ack;

	// Request drops for one cycle after an ack so the store can rearm
	assign spr_req = bus_req && spr_wr && !ack_q;
	assign spr_addr = 16'(wb_adr - `SPRITE_BASE);
	assign spr_pixel = wb_dat_w[2:0];

	assign wb_ack = reg_ack || spr_done;

	////////////////////////////////////////////////////////////
	// Card table and ack
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// All zero is hidden with face 0
			card_table <= '0;
			reg_ack <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_ack;
			reg_ack <= reg_go;
			if (reg_go && wb_we && wb_sel[0] && in_table) begin
				card_table[wb_adr[3:0]] <= card_entry_t'(wb_dat_w[5:0]);
			end
		end
	end

	// Sprite region and unmapped space read as zero
	always_ff @(posedge clk) begin
		if (reg_go) begin
			wb_dat_r <= in_table ? 32'(card_table[wb_adr[3:0]]) : '0;
		end
	end

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

//--- logic/card_display_top.sv
`include "card_cfg.svh"

module card_display_top import card_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`WB_ADR_W-1:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic [3:0] wb_sel,
	output logic wb_ack,
	output logic [31:0] wb_dat_r,
	output pixel_t rgb,
	output logic hsync,
	output logic vsync
);

	logic [9:0] hcount;
	logic [9:0] vcount;
	logic hsync_raw;
	logic vsync_raw;
	logic active;
	card_entry_t [15:0] card_table;
	logic rd_en;
	logic [15:0] rd_addr;
	pixel_t rd_pixel;
	logic spr_req;
	logic [15:0] spr_addr;
	pixel_t spr_pixel;
	logic spr_done;

	////////////////////////////////////////////////////////////
	// Video path
	////////////////////////////////////////////////////////////

	vga_timing i_timing (
		.clk(clk),
		.rst_n(rst_n),
		.hcount(hcount),
		.vcount(vcount),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.active(active)
	);

	card_renderer i_renderer (
		.clk(clk),
		.rst_n(rst_n),
		.hcount(hcount),
		.vcount(vcount),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.active(active),
		.card_table(card_table),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_pixel(rd_pixel),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

	////////////////////////////////////////////////////////////
	// Host side and shared sprite memory
	////////////////////////////////////////////////////////////

	sprite_store i_store (
		.clk(clk),
		.rst_n(rst_n),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_pixel(rd_pixel),
		.spr_req(spr_req),
		.spr_addr(spr_addr),
		.spr_pixel(spr_pixel),
		.spr_done(spr_done)
	);

	board_regs i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.card_table(card_table),
		.spr_req(spr_req),
		.spr_addr(spr_addr),
		.spr_pixel(spr_pixel),
		.spr_done(spr_done)
	);

endmodule

//--- logic/vga_timing.sv
`include "card_cfg.svh"

module vga_timing (
	input logic clk,
	input logic rst_n,
	output logic [9:0] hcount,
	output logic [9:0] vcount,
	output logic hsync_raw,
	output logic vsync_raw,
	output logic active
);

	logic h_last;
	logic v_last;
	logic h_in_sync;
	logic v_in_sync;

	assign h_last = hcount == 10'(`H_TOTAL - 1);
	assign v_last = vcount == 10'(`V_TOTAL - 1);

	////////////////////////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			if (h_last) begin
				hcount <= '0;
				// Line wraps, frame wraps after the last line
				if (v_last) begin
					vcount <= '0;
				end else begin
					vcount <= vcount + 10'd1;
				end
			end else begin
				hcount <= hcount + 10'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sync and blanking, straight from the counters
	////////////////////////////////////////////////////////////

	assign h_in_sync = (hcount >= 10'(`H_SYNC_START)) && (hcount < 10'(`H_SYNC_END));
	assign v_in_sync = (vcount >= 10'(`V_SYNC_START)) && (vcount < 10'(`V_SYNC_END));

	// Negative polarity
	assign hsync_raw = !h_in_sync;
	assign vsync_raw = !v_in_sync;

	assign active = (hcount < 10'(`H_ACTIVE)) && (vcount < 10'(`V_ACTIVE));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	-f all.f --top-module tb_card_display -o tb_card_display \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_card_display > sim.log 2>&1
grep -qx "Simulation passed" sim.log && echo "PASS" || { tail -n 20 sim.log; exit 1; }
